/* build.f */
+incdir+rtl
rtl/axiLitePkg.sv
rtl/mduPkg.sv
rtl/seqDivider.sv
rtl/seqMultiplier.sv
rtl/hiLoFile.sv
rtl/mduAxiSlave.sv
rtl/mduTop.sv
dv/mduTb.sv

/* Makefile */
# Verilator build and run of the MDU testbench

SIM = obj_dir/mduSim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f build.f --top-module mduTb -Mdir obj_dir -o mduSim
	out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* dv/mduTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mdu_consts.svh"

module mduTb
    import axiLitePkg::*;
    import mduPkg::*;
();

    // Handshake and busy poll limits
    localparam int WaitLimit = 64;
    localparam int BusyPolls = 100;

    logic clk;
    logic reset;
    axiReqT axiReq;
    axiRspT axiRsp;

    integer seed;
    int passCnt;
    int failCnt;
    logic timedOut;
    // Response code of the most recent read
    axiRespT lastRresp;

    mduTop i_mduTop (
        .clk(clk),
        .reset(reset),
        .axiReq(axiReq),
        .axiRsp(axiRsp)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // First timeout only, later tasks fall through
    task automatic noteTimeout(input string what);
        if (!timedOut) begin
            $display("Timeout: %s", what);
        end
        timedOut = 1'b1;
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (timedOut) return;
        assert (act === exp) begin
            passCnt++;
            $display("Pass %s value %h", name, act);
        end else begin
            failCnt++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    // AW and W together, bready held low for bDelay cycles after acceptance
    task automatic writeReg(input logic [5:0] addr, input logic [31:0] data, input int bDelay,
                            output logic [1:0] resp);
        int waitCnt;
        logic seen;
        resp = 2'b00;
        if (timedOut) return;
        axiReq.awvalid <= 1'b1;
        axiReq.awaddr <= addr;
        axiReq.wvalid <= 1'b1;
        axiReq.wdata <= data;
        axiReq.bready <= (bDelay == 0);
        waitCnt = 0;
        seen = 1'b0;
        // Outputs are registered, so pre-edge values give the handshake
        while (!seen && waitCnt < WaitLimit) begin
            @(posedge clk);
            seen = axiRsp.awready && axiRsp.wready;
            waitCnt++;
        end
        axiReq.awvalid <= 1'b0;
        axiReq.wvalid <= 1'b0;
        if (!seen) begin
            noteTimeout("write address and data never accepted");
            return;
        end
        repeat (bDelay) @(posedge clk);
        axiReq.bready <= 1'b1;
        waitCnt = 0;
        seen = 1'b0;
        while (!seen && waitCnt < WaitLimit) begin
            @(posedge clk);
            seen = axiRsp.bvalid;
            resp = axiRsp.bresp;
            waitCnt++;
        end
        axiReq.bready <= 1'b0;
        if (!seen) noteTimeout("write response never arrived");
    endtask

    // rready held low for rDelay cycles after the address is taken
    task automatic readReg(input logic [5:0] addr, input int rDelay, output logic [31:0] data);
        int waitCnt;
        logic seen;
        data = '0;
        if (timedOut) return;
        axiReq.arvalid <= 1'b1;
        axiReq.araddr <= addr;
        axiReq.rready <= (rDelay == 0);
        waitCnt = 0;
        seen = 1'b0;
        while (!seen && waitCnt < WaitLimit) begin
            @(posedge clk);
            seen = axiRsp.arready;
            waitCnt++;
        end
        axiReq.arvalid <= 1'b0;
        if (!seen) begin
            noteTimeout("read address never accepted");
            return;
        end
        repeat (rDelay) @(posedge clk);
        axiReq.rready <= 1'b1;
        waitCnt = 0;
        seen = 1'b0;
        while (!seen && waitCnt < WaitLimit) begin
            @(posedge clk);
            seen = axiRsp.rvalid;
            data = axiRsp.rdata;
            lastRresp = axiRsp.rresp;
            waitCnt++;
        end
        axiReq.rready <= 1'b0;
        if (!seen) noteTimeout("read data never arrived");
    endtask

    // Latency treated as variable, poll until busy drops
    task automatic waitIdle();
        logic [31:0] st;
        int polls;
        polls = 0;
        st = 32'h1;
        while (st[0] && polls < BusyPolls && !timedOut) begin
            readReg(`REG_STATUS, 0, st);
            polls++;
        end
        if (st[0]) noteTimeout("busy never cleared");
    endtask

    task automatic runOp(input logic [1:0] op, input logic [31:0] a, input logic [31:0] b,
                         output logic [31:0] hi, output logic [31:0] lo);
        logic [1:0] resp;
        writeReg(`REG_OPA, a, 0, resp);
        writeReg(`REG_OPB, b, 0, resp);
        writeReg(`REG_CMD, {30'b0, op}, 0, resp);
        waitIdle();
        readReg(`REG_HI, 0, hi);
        readReg(`REG_LO, 0, lo);
    endtask

    // Model is the full 64-bit unsigned product
    task automatic checkMultu(input string name, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] prod;
        logic [31:0] hi;
        logic [31:0] lo;
        prod = {32'b0, a} * {32'b0, b};
        runOp(`CMD_MULTU, a, b, hi, lo);
        checkWord({name, "_hi"}, prod[63:32], hi);
        checkWord({name, "_lo"}, prod[31:0], lo);
    endtask

    // LO is the quotient, HI the remainder
    task automatic checkDivu(input string name, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] hi;
        logic [31:0] lo;
        runOp(`CMD_DIVU, a, b, hi, lo);
        checkWord({name, "_lo"}, a / b, lo);
        checkWord({name, "_hi"}, a % b, hi);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        logic [31:0] hiV;
        logic [31:0] loV;
        logic [63:0] prod;
        logic [1:0] resp;
        int i;
        seed = 32'h9d96abb1;
        passCnt = 0;
        failCnt = 0;
        timedOut = 1'b0;
        clk = 1'b0;
        reset = 1'b1;
        axiReq = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Reset state
        readReg(`REG_STATUS, 0, data);
        checkWord("reset_status", 32'h0, data);
        readReg(`REG_HI, 0, data);
        checkWord("reset_hi", 32'h0, data);
        readReg(`REG_LO, 0, data);
        checkWord("reset_lo", 32'h0, data);

        // Multiply, directed corners then random
        checkMultu("multu_zero", 32'h0, 32'h1234_5678);
        checkMultu("multu_one", 32'h1, 32'hdead_beef);
        checkMultu("multu_ones", 32'hffff_ffff, 32'hffff_ffff);
        for (i = 0; i < 20; i++) begin
            a = $random(seed);
            b = $random(seed);
            checkMultu($sformatf("multu_rand%0d", i), a, b);
        end

        // Divide, includes dividend below divisor
        checkDivu("divu_small", 32'd100, 32'd7);
        checkDivu("divu_below", 32'd5, 32'd9);
        checkDivu("divu_by_one", 32'hffff_ffff, 32'h1);
        checkDivu("divu_self", 32'hffff_ffff, 32'hffff_ffff);
        checkDivu("divu_zero_num", 32'h0, 32'd5);
        for (i = 0; i < 20; i++) begin
            a = $random(seed);
            b = $random(seed);
            // Spread divisor sizes for varied quotient lengths
            b = b >> (i % 24);
            if (b == 32'h0) b = 32'h1;
            checkDivu($sformatf("divu_rand%0d", i), a, b);
        end

        // Divide by zero leaves HI and LO alone
        readReg(`REG_HI, 0, hiV);
        readReg(`REG_LO, 0, loV);
        runOp(`CMD_DIVU, 32'h1234, 32'h0, a, b);
        readReg(`REG_STATUS, 0, data);
        checkWord("divzero_status", 32'h2, data);
        checkWord("divzero_hi", hiV, a);
        checkWord("divzero_lo", loV, b);
        checkMultu("divzero_clear_op", 32'd3, 32'd4);
        readReg(`REG_STATUS, 0, data);
        checkWord("divzero_cleared", 32'h0, data);

        // Second command during a multiply is refused
        a = $random(seed);
        b = $random(seed);
        prod = {32'b0, a} * {32'b0, b};
        writeReg(`REG_OPA, a, 0, resp);
        writeReg(`REG_OPB, b, 0, resp);
        writeReg(`REG_CMD, {30'b0, `CMD_MULTU}, 0, resp);
        checkWord("busy_first_bresp", {30'b0, RESP_OKAY}, {30'b0, resp});
        writeReg(`REG_CMD, {30'b0, `CMD_DIVU}, 0, resp);
        checkWord("busy_second_bresp", {30'b0, RESP_SLVERR}, {30'b0, resp});
        waitIdle();
        readReg(`REG_HI, 0, data);
        checkWord("busy_result_hi", prod[63:32], data);
        readReg(`REG_LO, 0, data);
        checkWord("busy_result_lo", prod[31:0], data);

        // Operand readback under B and R back-pressure
        a = $random(seed);
        b = $random(seed);
        writeReg(`REG_OPA, a, 5, resp);
        writeReg(`REG_OPB, b, 3, resp);
        readReg(`REG_OPA, 6, data);
        checkWord("readback_opa", a, data);
        checkWord("readback_rresp", {30'b0, RESP_OKAY}, {30'b0, lastRresp});
        readReg(`REG_OPB, 4, data);
        checkWord("readback_opb", b, data);
        // Read-only HI ignores writes, unmapped reads zero
        readReg(`REG_HI, 0, hiV);
        writeReg(`REG_HI, ~hiV, 0, resp);
        checkWord("readonly_bresp", {30'b0, RESP_OKAY}, {30'b0, resp});
        readReg(`REG_HI, 0, data);
        checkWord("readonly_hi", hiV, data);
        readReg(6'h18, 0, data);
        checkWord("unmapped_read", 32'h0, data);
        checkWord("unmapped_rresp", {30'b0, RESP_OKAY}, {30'b0, lastRresp});

        $display("Checks: %0d passed, %0d failed", passCnt, failCnt);
        if (timedOut || failCnt != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/mduTop.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mdu_consts.svh"

module mduTop
    import axiLitePkg::*;
    import mduPkg::*;
(
    input logic clk,
    input logic reset,
    input axiReqT axiReq,
    output axiRspT axiRsp
);

    // Command fans out to both engines and the result file
    mduCmdT cmd;
    mduResT mulRes;
    mduResT divRes;
    logic divZero;
    mduStatusT status;
    logic [`MDU_WIDTH-1:0] hi;
    logic [`MDU_WIDTH-1:0] lo;

    mduAxiSlave i_mduAxiSlave (
        .clk(clk),
        .reset(reset),
        .axiReq(axiReq),
        .axiRsp(axiRsp),
        .cmd(cmd),
        .status(status),
        .hi(hi),
        .lo(lo)
    );

    seqMultiplier i_seqMultiplier (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .res(mulRes)
    );

    seqDivider i_seqDivider (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .res(divRes),
        .divZero(divZero)
    );

    // HI/LO and status registers
    hiLoFile i_hiLoFile (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .mulRes(mulRes),
        .divRes(divRes),
        .divZero(divZero),
        .hi(hi),
        .lo(lo),
        .status(status)
    );

endmodule

`default_nettype wire

/* rtl/mduAxiSlave.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mdu_consts.svh"

module mduAxiSlave
    import axiLitePkg::*;
    import mduPkg::*;
(
    input logic clk,
    input logic reset,
    input axiReqT axiReq,
    output axiRspT axiRsp,
    output mduCmdT cmd,
    input mduStatusT status,
    input logic [`MDU_WIDTH-1:0] hi,
    input logic [`MDU_WIDTH-1:0] lo
);

    // Write channel state, AW and W accepted together
    logic wrReadyQ;
    logic bValidQ;
    axiRespT bRespQ;
    logic wrFire;
    // Read channel state
    logic arReadyQ;
    logic rValidQ;
    logic [`MDU_WIDTH-1:0] rDataQ;
    logic [`MDU_WIDTH-1:0] rdMux;
    logic rdFire;
    // Operands and pending command
    logic [`MDU_WIDTH-1:0] opAQ;
    logic [`MDU_WIDTH-1:0] opBQ;
    logic startQ;
    mduOpT opQ;
    mduOpT wrOp;
    logic cmdWrite;
    logic cmdBusy;

    assign wrFire = wrReadyQ && axiReq.awvalid && axiReq.wvalid;
    assign rdFire = arReadyQ && axiReq.arvalid;
    assign cmdWrite = wrFire && (axiReq.awaddr == `REG_CMD);
    assign wrOp = mduOpT'(axiReq.wdata[1:0]);
    // Start cycle counts as busy, status lags it by one
    assign cmdBusy = status.busy || startQ;

    always_ff @(posedge clk) begin
        if (reset) begin
            wrReadyQ <= 1'b0;
            bValidQ <= 1'b0;
            startQ <= 1'b0;
            opQ <= NONE;
        end else begin
            startQ <= 1'b0;
            wrReadyQ <= !wrReadyQ && !bValidQ && axiReq.awvalid && axiReq.wvalid;
            if (bValidQ && axiReq.bready) begin
                bValidQ <= 1'b0;
            end
            if (wrFire) begin
                bValidQ <= 1'b1;
            end
            // Unknown op codes are dropped silently
            if (cmdWrite && !cmdBusy && ((wrOp == MULTU) || (wrOp == DIVU))) begin
                startQ <= 1'b1;
                opQ <= wrOp;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrFire) begin
            bRespQ <= (cmdWrite && cmdBusy) ? RESP_SLVERR : RESP_OKAY;
            if (axiReq.awaddr == `REG_OPA) begin
                opAQ <= axiReq.wdata;
            end
            if (axiReq.awaddr == `REG_OPB) begin
                opBQ <= axiReq.wdata;
            end
        end
    end

    always_comb begin
        case (axiReq.araddr)
            `REG_OPA: rdMux = opAQ;
            `REG_OPB: rdMux = opBQ;
            `REG_STATUS: rdMux = {{(`MDU_WIDTH-2){1'b0}}, status.divZero, status.busy};
            `REG_HI: rdMux = hi;
            `REG_LO: rdMux = lo;
            default: rdMux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arReadyQ <= 1'b0;
            rValidQ <= 1'b0;
        end else begin
            arReadyQ <= !arReadyQ && !rValidQ && axiReq.arvalid;
            if (rValidQ && axiReq.rready) begin
                rValidQ <= 1'b0;
            end
            if (rdFire) begin
                rValidQ <= 1'b1;
            end
        end
    end

    // Data captured at the AR handshake
    always_ff @(posedge clk) begin
        if (rdFire) begin
            rDataQ <= rdMux;
        end
    end

    assign axiRsp.awready = wrReadyQ;
    assign axiRsp.wready = wrReadyQ;
    assign axiRsp.bvalid = bValidQ;
    assign axiRsp.bresp = bRespQ;
    assign axiRsp.arready = arReadyQ;
    assign axiRsp.rvalid = rValidQ;
    assign axiRsp.rdata = rDataQ;
    assign axiRsp.rresp = RESP_OKAY;

    assign cmd.start = startQ;
    assign cmd.op = opQ;
    assign cmd.opA = opAQ;
    assign cmd.opB = opBQ;

    // B response held across master back-pressure
    bvalidHeld: assert property (@(posedge clk) disable iff (reset)
        bValidQ && !axiReq.bready |=> bValidQ);

endmodule

`default_nettype wire

/* rtl/hiLoFile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mdu_consts.svh"

module hiLoFile
    import mduPkg::*;
(
    input logic clk,
    input logic reset,
    input mduCmdT cmd,
    input mduResT mulRes,
    input mduResT divRes,
    input logic divZero,
    output logic [`MDU_WIDTH-1:0] hi,
    output logic [`MDU_WIDTH-1:0] lo,
    output mduStatusT status
);

    logic busyQ;
    logic divZeroQ;
    logic engineStart;

    // Zero-divisor DIVU is accepted but never runs
    assign engineStart = cmd.start && ((cmd.op == MULTU) || ((cmd.op == DIVU) && !divZero));

    always_ff @(posedge clk) begin
        if (reset) begin
            busyQ <= 1'b0;
            divZeroQ <= 1'b0;
        end else begin
            if (engineStart) begin
                busyQ <= 1'b1;
            end else if (mulRes.done || divRes.done) begin
                busyQ <= 1'b0;
            end
            // Any new command replaces the old flag
            if (cmd.start) begin
                divZeroQ <= divZero;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (mulRes.done) begin
            hi <= mulRes.hi;
            lo <= mulRes.lo;
        end else if (divRes.done) begin
            hi <= divRes.hi;
            lo <= divRes.lo;
        end
    end

    assign status.busy = busyQ;
    assign status.divZero = divZeroQ;

    // Only one engine runs at a time
    singleDone: assert property (@(posedge clk) disable iff (reset)
        !(mulRes.done && divRes.done));

endmodule

`default_nettype wire

/* rtl/seqMultiplier.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mdu_consts.svh"

module seqMultiplier
    import mduPkg::*;
(
    input logic clk,
    input logic reset,
    input mduCmdT cmd,
    output mduResT res
);

    localparam int CntW = $clog2(`MDU_STEPS);
    localparam int LastStep = `MDU_STEPS - 1;

    logic running;
    logic [CntW-1:0] stepCnt;
    logic startMul;
    logic lastStep;
    // Multiplicand moves left, multiplier moves right
    logic [2*`MDU_WIDTH-1:0] mcandQ;
    logic [`MDU_WIDTH-1:0] mplrQ;
    logic [2*`MDU_WIDTH-1:0] accQ;
    logic [2*`MDU_WIDTH-1:0] accNext;

    assign startMul = cmd.start && (cmd.op == MULTU);
    assign lastStep = running && (stepCnt == CntW'(LastStep));

    // Partial product only when the current multiplier bit is set
    assign accNext = mplrQ[0] ? (accQ + mcandQ) : accQ;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            stepCnt <= '0;
        end else if (startMul) begin
            running <= 1'b1;
            stepCnt <= '0;
        end else if (running) begin
            stepCnt <= stepCnt + 1'b1;
            if (lastStep) begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startMul) begin
            mcandQ <= {{`MDU_WIDTH{1'b0}}, cmd.opA};
            mplrQ <= cmd.opB;
            accQ <= '0;
        end else if (running) begin
            mcandQ <= {mcandQ[2*`MDU_WIDTH-2:0], 1'b0};
            mplrQ <= {1'b0, mplrQ[`MDU_WIDTH-1:1]};
            accQ <= accNext;
        end
    end

    assign res.done = lastStep;
    assign res.hi = accNext[2*`MDU_WIDTH-1:`MDU_WIDTH];
    assign res.lo = accNext[`MDU_WIDTH-1:0];

    // Done lands exactly one run length after the start pulse
    doneOnlyRunning: assert property (@(posedge clk) disable iff (reset)
        res.done |-> running && $past(startMul, `MDU_STEPS));

endmodule

`default_nettype wire

/* rtl/seqDivider.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mdu_consts.svh"

module seqDivider
    import mduPkg::*;
(
    input logic clk,
    input logic reset,
    input mduCmdT cmd,
    output mduResT res,
    output logic divZero
);

    localparam int CntW = $clog2(`MDU_STEPS);
    localparam int LastStep = `MDU_STEPS - 1;

    logic running;
    logic [CntW-1:0] stepCnt;
    logic startDiv;
    logic lastStep;
    // Datapath registers
    logic [`MDU_WIDTH-1:0] numQ;
    logic [`MDU_WIDTH-1:0] denQ;
    logic [`MDU_WIDTH-1:0] remQ;
    logic [`MDU_WIDTH-1:0] quoQ;
    // One step of the restoring division
    logic [`MDU_WIDTH:0] remShift;
    logic remGeDen;
    logic [`MDU_WIDTH-1:0] remNext;
    logic [`MDU_WIDTH-1:0] quoNext;

    assign startDiv = cmd.start && (cmd.op == DIVU);
    // Zero divisor never starts the engine
    assign divZero = startDiv && (cmd.opB == '0);
    assign lastStep = running && (stepCnt == CntW'(LastStep));

    // Bring down the next numerator bit, MSB first
    assign remShift = {remQ, numQ[`MDU_WIDTH-1]};
    assign remGeDen = (remShift >= {1'b0, denQ});
    // Difference fits in the width because remainder stays below divisor
    assign remNext = remGeDen ? `MDU_WIDTH'(remShift - {1'b0, denQ})
                              : remShift[`MDU_WIDTH-1:0];
    assign quoNext = {quoQ[`MDU_WIDTH-2:0], remGeDen};

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            stepCnt <= '0;
        end else if (startDiv && !divZero) begin
            running <= 1'b1;
            stepCnt <= '0;
        end else if (running) begin
            stepCnt <= stepCnt + 1'b1;
            if (lastStep) begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startDiv && !divZero) begin
            numQ <= cmd.opA;
            denQ <= cmd.opB;
            remQ <= '0;
            quoQ <= '0;
        end else if (running) begin
            numQ <= {numQ[`MDU_WIDTH-2:0], 1'b0};
            remQ <= remNext;
            quoQ <= quoNext;
        end
    end

    // Last step result goes straight out, latched by the HI/LO file
    assign res.done = lastStep;
    assign res.hi = remNext;
    assign res.lo = quoNext;

    // Slave must hold off commands until the previous divide retires
    startWhileRunning: assert property (@(posedge clk) disable iff (reset)
        startDiv |-> !running);

endmodule

`default_nettype wire

/* rtl/mduPkg.sv */
`default_nettype none

`include "mdu_consts.svh"

package mduPkg;

    // Engine select, codes match the CMD register
    typedef enum logic [1:0] {
        NONE = 2'd0,
        MULTU = `CMD_MULTU,
        DIVU = `CMD_DIVU
    } mduOpT;

    // Slave to engines, start is a one-cycle pulse
    typedef struct packed {
        logic start;
        mduOpT op;
        logic [`MDU_WIDTH-1:0] opA;
        logic [`MDU_WIDTH-1:0] opB;
    } mduCmdT;

    // Engine result, hi and lo valid with done
    typedef struct packed {
        logic done;
        logic [`MDU_WIDTH-1:0] hi;
        logic [`MDU_WIDTH-1:0] lo;
    } mduResT;

    // Status bits seen by the host
    typedef struct packed {
        logic busy;
        logic divZero;
    } mduStatusT;

endpackage

`default_nettype wire

/* rtl/axiLitePkg.sv */
`default_nettype none

`include "mdu_consts.svh"

package axiLitePkg;

    // Response codes on B and R
    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axiRespT;

    // Everything the master drives
    typedef struct packed {
        logic awvalid;
        logic [`MDU_ADDR_W-1:0] awaddr;
        logic wvalid;
        logic [`MDU_WIDTH-1:0] wdata;
        logic bready;
        logic arvalid;
        logic [`MDU_ADDR_W-1:0] araddr;
        logic rready;
    } axiReqT;

    // Everything the slave drives
    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        axiRespT bresp;
        logic arready;
        logic rvalid;
        logic [`MDU_WIDTH-1:0] rdata;
        axiRespT rresp;
    } axiRspT;

endpackage

`default_nettype wire

/* rtl/mdu_consts.svh */
`ifndef MDU_CONSTS_SVH
`define MDU_CONSTS_SVH

// Operand width, fixed by the 32-bit register map
`define MDU_WIDTH 32
// One result bit per cycle
`define MDU_STEPS 32
// AXI4-Lite byte address width
`define MDU_ADDR_W 6

// Register byte offsets
`define REG_OPA 6'h00
`define REG_OPB 6'h04
`define REG_CMD 6'h08
`define REG_STATUS 6'h0C
`define REG_HI 6'h10
`define REG_LO 6'h14

// Command op codes in CMD[1:0]
`define CMD_MULTU 2'd1
`define CMD_DIVU 2'd2

`endif
